/* Bender.yml */
package:
  name: dsi3_channel

sources:
  - include_dirs:
      - common
    files:
      - common/dsi3_pkg.sv
      - rtl/dsi3_crc8.sv
      - rtl/dsi3_timebase.sv
      - dsi3_channel/dsi3_crm_transmitter.sv
      - dsi3_channel/dsi3_command_sequencer.sv
      - dsi3_channel/dsi3_channel.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/dsi3_checker.sv
      - verification/tb_dsi3_channel.sv

/* build.f */
+incdir+common
common/dsi3_pkg.sv
rtl/dsi3_crc8.sv
rtl/dsi3_timebase.sv
dsi3_channel/dsi3_crm_transmitter.sv
dsi3_channel/dsi3_command_sequencer.sv
dsi3_channel/dsi3_channel.sv
verification/dsi3_checker.sv
verification/tb_dsi3_channel.sv

/* common/dsi3_macros.svh */
// Constants shared by the DSI3 channel and its testbench.
// Tick and bit timing are in clock cycles and assume a 50 MHz clock.
`ifndef DSI3_MACROS_SVH
`define DSI3_MACROS_SVH

// ******************************
// word and frame sizes
// ******************************
`define DSI3_WORD_WIDTH 16
`define DSI3_FRAME_BITS 32
`define DSI3_CHANNELS 4

// ******************************
// timing
// ******************************
`define DSI3_TICK_CYCLES 50
`define DSI3_STARTUP_TICKS 10
`define DSI3_BIT_CYCLES 8

// crc-8 over the two CRM data words, no final xor.
`define DSI3_CRC_POLY 8'h1D
`define DSI3_CRC_SEED 8'hFF

`endif

/* common/dsi3_pkg.sv */
// Types for one DSI3 channel of the command sequencer.
// Opcode values follow the command word layout, opcode in bits 15 to 12.
`default_nettype none

package dsi3_pkg;

	`include "dsi3_macros.svh"

	typedef logic [`DSI3_WORD_WIDTH-1:0] dsi3_word_t;
	typedef logic [7:0] dsi3_crc_t;
	typedef logic [14:0] dsi3_wait_t;
	typedef logic [`DSI3_FRAME_BITS-1:0] dsi3_frame_t;

	// bit 0 is the command error, bit 1 is enable lost.
	typedef logic [1:0] dsi3_errors_t;

	typedef enum logic [3:0] {
		CRM  = 4'd1,
		WAIT = 4'd2
	} dsi3_opcode_e;

	typedef enum logic [2:0] {
		IDLE,
		DECODE,
		CRM_HIGH,
		CRM_LOW,
		CRM_START,
		CRM_SEND,
		WAIT_READ,
		WAITING
	} dsi3_seq_state_e;

endpackage

`default_nettype wire

/* dsi3_channel/dsi3_channel.sv */
// One DSI3 channel: timebase, command sequencer and CRM transmitter.
// The command queue is read through a read, ready and empty handshake.
`timescale 1ns/1ps
`default_nettype none

module dsi3_channel import dsi3_pkg::*; #(
	parameter int CHANNEL = 0
) (
	input  logic         clk_rst,
	input  logic         reset_command,
	input  logic         i_cmd_empty,
	input  logic         i_cmd_ready,
	input  dsi3_word_t   i_cmd_data,
	input  logic         i_transceiver_enable,
	input  logic         i_stop_transmission,
	input  logic         i_crc_enable,
	input  logic         i_clear_errors,
	output logic         o_cmd_read,
	output logic         o_clear_queue,
	output logic         o_start,
	output logic         o_finished,
	output logic         o_tx,
	output logic         o_tx_active,
	output logic         o_busy,
	output dsi3_errors_t o_errors,
	output logic         o_interrupt
);

	logic        tick_1us, started_up, abort;
	dsi3_frame_t frame;

	dsi3_timebase u_dsi3_timebase (
		.clk_rst             (clk_rst),
		.reset_command       (reset_command),
		.i_transceiver_enable(i_transceiver_enable),
		.o_tick_1us          (tick_1us),
		.o_started_up        (started_up)
	);

	dsi3_command_sequencer #(
		.CHANNEL(CHANNEL)
	) u_dsi3_command_sequencer (
		.clk_rst             (clk_rst),
		.reset_command       (reset_command),
		.i_cmd_empty         (i_cmd_empty),
		.i_cmd_ready         (i_cmd_ready),
		.i_cmd_data          (i_cmd_data),
		.i_tick_1us          (tick_1us),
		.i_started_up        (started_up),
		.i_transceiver_enable(i_transceiver_enable),
		.i_stop_transmission (i_stop_transmission),
		.i_crc_enable        (i_crc_enable),
		.i_clear_errors      (i_clear_errors),
		.i_finished          (o_finished),
		.o_cmd_read          (o_cmd_read),
		.o_clear_queue       (o_clear_queue),
		.o_start             (o_start),
		.o_frame             (frame),
		.o_abort             (abort),
		.o_busy              (o_busy),
		.o_errors            (o_errors),
		.o_interrupt         (o_interrupt)
	);

	dsi3_crm_transmitter u_dsi3_crm_transmitter (
		.clk_rst      (clk_rst),
		.reset_command(reset_command),
		.i_start      (o_start),
		.i_frame      (frame),
		.i_abort      (abort),
		.o_tx         (o_tx),
		.o_tx_active  (o_tx_active),
		.o_finished   (o_finished)
	);

endmodule

`default_nettype wire

/* dsi3_channel/dsi3_command_sequencer.sv */
// Reads commands only after transceiver start-up and while no stop is requested.
// Error flags are sticky; a set in the same cycle as a clear wins.
// CHANNEL must be below the width of the channel-select field.
`timescale 1ns/1ps
`default_nettype none

`include "dsi3_macros.svh"

module dsi3_command_sequencer import dsi3_pkg::*; #(
	parameter int CHANNEL = 0
) (
	input  logic         clk_rst,
	input  logic         reset_command,
	input  logic         i_cmd_empty,
	input  logic         i_cmd_ready,
	input  dsi3_word_t   i_cmd_data,
	input  logic         i_tick_1us,
	input  logic         i_started_up,
	input  logic         i_transceiver_enable,
	input  logic         i_stop_transmission,
	input  logic         i_crc_enable,
	input  logic         i_clear_errors,
	input  logic         i_finished,
	output logic         o_cmd_read,
	output logic         o_clear_queue,
	output logic         o_start,
	output dsi3_frame_t  o_frame,
	output logic         o_abort,
	output logic         o_busy,
	output dsi3_errors_t o_errors,
	output logic         o_interrupt
);

	dsi3_seq_state_e state, state_next;
	dsi3_word_t      command, data_high, data_low, crc_data;
	dsi3_crc_t       crc, crc_seed, crc_next;
	dsi3_wait_t      wait_count;
	dsi3_errors_t    errors;
	logic            store_command, operand_taken, count_down;
	logic            set_command_error, set_enable_lost;

	// ******************************
	// next state
	// ******************************
	always_comb begin
		state_next = state;
		o_cmd_read = 1'b0;
		o_clear_queue = 1'b0;
		o_start = 1'b0;
		o_abort = 1'b0;
		store_command = 1'b0;
		operand_taken = 1'b0;
		count_down = 1'b0;
		set_command_error = 1'b0;
		set_enable_lost = 1'b0;

		if ((state != IDLE) && (i_stop_transmission || !i_transceiver_enable)) begin
			state_next = IDLE;
			o_abort = 1'b1;
			set_enable_lost = !i_transceiver_enable;
		end else begin
			case (state)
				IDLE: begin
					if (!i_cmd_empty && i_started_up && !i_stop_transmission) begin
						o_cmd_read = 1'b1;
						if (i_cmd_ready) begin
							store_command = 1'b1;
							state_next = DECODE;
						end
					end
				end
				DECODE: begin
					if (!command[CHANNEL]) begin
						set_command_error = 1'b1;
					end else begin
						case (dsi3_opcode_e'(command[15:12]))
							CRM:     state_next = CRM_HIGH;
							WAIT:    state_next = WAIT_READ;
							default: set_command_error = 1'b1;
						endcase
					end
				end
				CRM_HIGH, CRM_LOW, WAIT_READ: begin
					if (i_cmd_empty) begin
						set_command_error = 1'b1;
					end else begin
						o_cmd_read = 1'b1;
						if (i_cmd_ready) begin
							operand_taken = 1'b1;
							case (state)
								CRM_HIGH: state_next = CRM_LOW;
								CRM_LOW:  state_next = CRM_START;
								default:  state_next = WAITING;
							endcase
						end
					end
				end
				CRM_START: begin
					o_start = 1'b1;
					state_next = CRM_SEND;
				end
				CRM_SEND: begin
					if (i_finished) begin
						state_next = IDLE;
					end
				end
				WAITING: begin
					if (i_tick_1us) begin
						if (wait_count == '0) begin
							state_next = IDLE;
						end else begin
							count_down = 1'b1;
						end
					end
				end
				default: state_next = IDLE;
			endcase
			if (set_command_error) begin
				// the rest of the broken command is flushed from the queue.
				o_clear_queue = 1'b1;
				state_next = IDLE;
			end
		end
	end

	always_ff @(posedge clk_rst) begin
		if (reset_command) begin
			state <= IDLE;
			errors <= '0;
		end else begin
			state <= state_next;
			errors <= (i_clear_errors ? '0 : errors) | {set_enable_lost, set_command_error};
		end
	end

	// ******************************
	// command and operand registers
	// ******************************
	always_ff @(posedge clk_rst) begin
		if (store_command) begin
			command <= i_cmd_data;
		end
		if (operand_taken) begin
			case (state)
				CRM_HIGH: begin
					data_high <= i_cmd_data;
					crc <= crc_next;
				end
				CRM_LOW: begin
					data_low <= i_cmd_data;
					crc <= crc_next;
				end
				default: wait_count <= i_cmd_data[14:0];
			endcase
		end else if (count_down) begin
			wait_count <= wait_count - 1'b1;
		end
	end

	// second step runs over the low word with its crc byte still zero.
	always_comb begin
		crc_seed = `DSI3_CRC_SEED;
		crc_data = i_cmd_data;
		if (state == CRM_LOW) begin
			crc_seed = crc;
			crc_data[7:0] = 8'h00;
		end
	end

	dsi3_crc8 u_dsi3_crc8 (
		.i_seed(crc_seed),
		.i_data(crc_data),
		.o_crc (crc_next)
	);

	assign o_frame = {data_high, data_low[15:8], i_crc_enable ? crc : data_low[7:0]};
	assign o_busy = (state != IDLE);
	assign o_errors = errors;
	assign o_interrupt = |errors;

endmodule

`default_nettype wire

/* dsi3_channel/dsi3_crm_transmitter.sv */
// Sends one frame msb first; o_tx is low whenever no frame is active.
// A start while a frame is running is ignored.
`timescale 1ns/1ps
`default_nettype none

`include "dsi3_macros.svh"

module dsi3_crm_transmitter import dsi3_pkg::*; (
	input  logic        clk_rst,
	input  logic        reset_command,
	input  logic        i_start,
	input  dsi3_frame_t i_frame,
	input  logic        i_abort,
	output logic        o_tx,
	output logic        o_tx_active,
	output logic        o_finished
);

	localparam int CYCLE_WIDTH = $clog2(`DSI3_BIT_CYCLES);
	localparam int BIT_WIDTH = $clog2(`DSI3_FRAME_BITS);

	dsi3_frame_t            shift_reg;
	logic [CYCLE_WIDTH-1:0] cycle_count;
	logic [BIT_WIDTH-1:0]   bit_count;
	logic                   bit_done;

	assign bit_done = (cycle_count == CYCLE_WIDTH'(`DSI3_BIT_CYCLES - 1));

	always_ff @(posedge clk_rst) begin
		if (reset_command || i_abort) begin
			o_tx_active <= 1'b0;
			o_finished <= 1'b0;
			cycle_count <= '0;
			bit_count <= '0;
		end else begin
			o_finished <= 1'b0;
			if (!o_tx_active) begin
				o_tx_active <= i_start;
				cycle_count <= '0;
				bit_count <= '0;
			end else if (bit_done) begin
				cycle_count <= '0;
				bit_count <= bit_count + 1'b1;
				if (bit_count == BIT_WIDTH'(`DSI3_FRAME_BITS - 1)) begin
					o_tx_active <= 1'b0;
					o_finished <= 1'b1;
				end
			end else begin
				cycle_count <= cycle_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_rst) begin
		if (!o_tx_active && i_start) begin
			shift_reg <= i_frame;
		end else if (o_tx_active && bit_done) begin
			shift_reg <= {shift_reg[`DSI3_FRAME_BITS-2:0], 1'b0};
		end
	end

	assign o_tx = o_tx_active & shift_reg[`DSI3_FRAME_BITS-1];

endmodule

`default_nettype wire

/* rtl/dsi3_crc8.sv */
// Purely combinational, one 16-bit word per evaluation.
// Chain two instances or feed the result back as seed for longer data.
`timescale 1ns/1ps
`default_nettype none

`include "dsi3_macros.svh"

module dsi3_crc8 import dsi3_pkg::*; (
	input  dsi3_crc_t  i_seed,
	input  dsi3_word_t i_data,
	output dsi3_crc_t  o_crc
);

	always_comb begin
		dsi3_crc_t crc;
		logic      feedback;
		crc = i_seed;
		// data goes in msb first.
		for (int i = `DSI3_WORD_WIDTH - 1; i >= 0; i--) begin
			feedback = crc[7] ^ i_data[i];
			crc = {crc[6:0], 1'b0};
			if (feedback) begin
				crc = crc ^ `DSI3_CRC_POLY;
			end
		end
		o_crc = crc;
	end

endmodule

`default_nettype wire

/* rtl/dsi3_timebase.sv */
// The tick divider is free running, so the first tick after any event
// arrives with an arbitrary phase of up to one tick period.
`timescale 1ns/1ps
`default_nettype none

`include "dsi3_macros.svh"

module dsi3_timebase (
	input  logic clk_rst,
	input  logic reset_command,
	input  logic i_transceiver_enable,
	output logic o_tick_1us,
	output logic o_started_up
);

	localparam int DIV_WIDTH = $clog2(`DSI3_TICK_CYCLES);
	localparam int STARTUP_WIDTH = $clog2(`DSI3_STARTUP_TICKS + 1);

	logic [DIV_WIDTH-1:0]     div_count;
	logic [STARTUP_WIDTH-1:0] startup_count;

	assign o_tick_1us = (div_count == DIV_WIDTH'(`DSI3_TICK_CYCLES - 1));

	always_ff @(posedge clk_rst) begin
		if (reset_command || o_tick_1us) begin
			div_count <= '0;
		end else begin
			div_count <= div_count + 1'b1;
		end
	end

	// ******************************
	// start-up qualification
	// ******************************
	always_ff @(posedge clk_rst) begin
		if (reset_command || !i_transceiver_enable) begin
			startup_count <= '0;
		end else if (o_tick_1us && !o_started_up) begin
			startup_count <= startup_count + 1'b1;
		end
	end

	// enable is checked directly so the first low cycle already blocks new commands.
	assign o_started_up = i_transceiver_enable &&
		(startup_count == STARTUP_WIDTH'(`DSI3_STARTUP_TICKS));

endmodule

`default_nettype wire

/* verification/dsi3_checker.sv */
// Watches the transmit side of the channel and compares each CRM frame with the model.
// Expected frames are queued by the testbench in the order the commands were loaded.
`timescale 1ns/1ps
`default_nettype none

`include "dsi3_macros.svh"

module dsi3_checker import dsi3_pkg::*; (
	input logic clk_rst,
	input logic reset_command,
	input logic i_start,
	input logic i_tx,
	input logic i_tx_active,
	input logic i_finished,
	input logic i_clear_queue
);

	int          error_count = 0;
	int          frame_count = 0;
	int          clear_count = 0;
	int          active_cycles = 0;
	logic        was_active = 1'b0;
	logic        start_seen = 1'b0;
	logic        aborting = 1'b0;
	logic        frame_expected = 1'b0;
	dsi3_frame_t expected_q[$];
	dsi3_frame_t expected, received;

	// ******************************
	// reference model
	// ******************************
	function automatic dsi3_crc_t crc_step(input dsi3_crc_t seed, input dsi3_word_t data);
		dsi3_crc_t crc;
		crc = seed;
		for (int i = 15; i >= 0; i--) begin
			if (crc[7] != data[i]) begin
				crc = (crc << 1) ^ `DSI3_CRC_POLY;
			end else begin
				crc = crc << 1;
			end
		end
		return crc;
	endfunction

	task automatic expect_frame(input dsi3_word_t high, input dsi3_word_t low, input logic crc_on);
		dsi3_crc_t first, second;
		first = crc_step(`DSI3_CRC_SEED, high);
		second = crc_step(first, {low[15:8], 8'h00});
		expected_q.push_back({high, low[15:8], crc_on ? second : low[7:0]});
	endtask

	task automatic expect_abort();
		aborting = 1'b1;
	endtask

	function automatic int pending_frames();
		return expected_q.size();
	endfunction

	task automatic flag_error(input string msg);
		error_count++;
		$display("Fail %0t: %s", $time, msg);
	endtask

	task automatic check_value(input string what, input int got, input int exp);
		if (got != exp) begin
			flag_error($sformatf("%s is %0d, expected %0d", what, got, exp));
		end
	endtask

	// ******************************
	// frame monitor
	// ******************************
	always @(negedge clk_rst) begin
		if (reset_command) begin
			was_active = 1'b0;
			start_seen = 1'b0;
			active_cycles = 0;
		end else begin
			if (i_clear_queue) begin
				clear_count++;
			end
			if (i_tx_active) begin
				if (!was_active) begin
					active_cycles = 0;
					received = '0;
					frame_expected = 1'b0;
					if (!aborting) begin
						if (expected_q.size() == 0) begin
							flag_error("frame sent with no CRM command pending");
						end else begin
							expected = expected_q.pop_front();
							frame_expected = 1'b1;
						end
					end
				end
				// sample in the middle of each bit period.
				if (active_cycles % `DSI3_BIT_CYCLES == `DSI3_BIT_CYCLES / 2) begin
					received = {received[`DSI3_FRAME_BITS-2:0], i_tx};
				end
				active_cycles++;
			end else if (was_active) begin
				if (aborting) begin
					if (i_finished) begin
						flag_error("finished pulse after an aborted frame");
					end
					aborting = 1'b0;
				end else begin
					check_value("finished at end of frame", i_finished, 1);
					check_value("frame length in cycles", active_cycles,
						`DSI3_FRAME_BITS * `DSI3_BIT_CYCLES);
					if (frame_expected && received != expected) begin
						flag_error($sformatf("frame %h, expected %h", received, expected));
					end
					frame_count++;
				end
			end else if (i_finished) begin
				flag_error("finished pulse with no frame");
			end
			// the start pulse comes exactly one cycle before tx active rises.
			if (start_seen != (i_tx_active && !was_active)) begin
				flag_error("start pulse and rise of tx active are not one cycle apart");
			end
			was_active = i_tx_active;
			start_seen = i_start;
		end
	end

endmodule

`default_nettype wire

/* verification/tb_dsi3_channel.sv */
// Random command stream for one channel with CHANNEL 0 and a 50 MHz clock.
// The queue model flushes itself whenever the DUT requests a queue clear.
`timescale 1ns/1ps
`default_nettype none

`include "dsi3_macros.svh"

module tb_dsi3_channel import dsi3_pkg::*; ();

	localparam int COMMANDS = 40;
	localparam int MAX_CYCLES = (COMMANDS + 4) * 400 +
		3 * (`DSI3_STARTUP_TICKS + 1) * `DSI3_TICK_CYCLES;

	logic clk_rst = 1'b0;
	logic reset_command, i_cmd_empty, i_cmd_ready;
	logic i_transceiver_enable, i_stop_transmission, i_crc_enable, i_clear_errors;
	dsi3_word_t i_cmd_data;
	logic o_cmd_read, o_clear_queue, o_start, o_finished, o_tx, o_tx_active, o_busy;
	logic o_interrupt;
	dsi3_errors_t o_errors;

	integer     seed;
	int         cycles = 0;
	int         expected_reads = 0;
	int         expected_flushed = 0;
	int         popped_words = 0;
	int         cleared_words = 0;
	dsi3_word_t cmd_q[$];

	dsi3_channel #(.CHANNEL(0)) u_dsi3_channel (
		.clk_rst(clk_rst), .reset_command(reset_command),
		.i_cmd_empty(i_cmd_empty), .i_cmd_ready(i_cmd_ready), .i_cmd_data(i_cmd_data),
		.i_transceiver_enable(i_transceiver_enable),
		.i_stop_transmission(i_stop_transmission),
		.i_crc_enable(i_crc_enable), .i_clear_errors(i_clear_errors),
		.o_cmd_read(o_cmd_read), .o_clear_queue(o_clear_queue), .o_start(o_start),
		.o_finished(o_finished), .o_tx(o_tx), .o_tx_active(o_tx_active),
		.o_busy(o_busy), .o_errors(o_errors), .o_interrupt(o_interrupt)
	);

	dsi3_checker u_checker (
		.clk_rst(clk_rst), .reset_command(reset_command), .i_start(o_start), .i_tx(o_tx),
		.i_tx_active(o_tx_active), .i_finished(o_finished), .i_clear_queue(o_clear_queue)
	);

	initial begin
		forever begin
			#10 clk_rst = ~clk_rst;
		end
	end

	always @(posedge clk_rst) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ******************************
	// command queue model
	// ******************************
	initial begin
		logic        fire, flush;
		logic [31:0] r;
		forever begin
			@(negedge clk_rst);
			fire = o_cmd_read && i_cmd_ready;
			flush = o_clear_queue;
			@(posedge clk_rst);
			#2;
			if (flush) begin
				cleared_words += cmd_q.size();
				cmd_q.delete();
			end else if (fire) begin
				void'(cmd_q.pop_front());
				popped_words++;
			end
			r = $random(seed);
			i_cmd_ready = (r[1:0] != 2'b00);
			i_cmd_empty = (cmd_q.size() == 0);
			i_cmd_data = i_cmd_empty ? '0 : cmd_q[0];
		end
	end

	task automatic next_cycle();
		@(posedge clk_rst);
		#2;
	endtask

	task automatic push_word(input dsi3_word_t word);
		cmd_q.push_back(word);
	endtask

	task automatic wait_idle();
		@(negedge clk_rst);
		while (o_busy || cmd_q.size() != 0) begin
			@(negedge clk_rst);
		end
	endtask

	task automatic load_crm(input logic operands);
		logic [31:0] r;
		dsi3_word_t  high, low;
		r = $random(seed);
		high = dsi3_word_t'($random(seed));
		low = dsi3_word_t'($random(seed));
		next_cycle();
		i_crc_enable = r[16];
		@(negedge clk_rst);
		push_word({4'd1, r[11:1], 1'b1});
		expected_reads++;
		if (operands) begin
			push_word(high);
			push_word(low);
			expected_reads += 2;
			u_checker.expect_frame(high, low, r[16]);
		end
	endtask

	task automatic run_wait(input int n);
		int count;
		int target;
		@(negedge clk_rst);
		target = popped_words + 2;
		push_word({4'd2, 11'($random(seed)), 1'b1});
		push_word({1'b0, 15'(n)});
		expected_reads += 2;
		@(negedge clk_rst);
		while (popped_words != target) begin
			@(negedge clk_rst);
		end
		count = 0;
		while (o_busy) begin
			count++;
			@(negedge clk_rst);
		end
		if (count < n * `DSI3_TICK_CYCLES || count > (n + 1) * `DSI3_TICK_CYCLES + 2) begin
			u_checker.flag_error($sformatf("wait of %0d busy for %0d cycles", n, count));
		end
	endtask

	task automatic run_error(input dsi3_word_t command, input string what);
		int clears;
		clears = u_checker.clear_count;
		if (command[15:12] == 4'd1 && command[0]) begin
			load_crm(1'b0);
		end else begin
			@(negedge clk_rst);
			push_word(command);
			// the word behind a bad command is never read and goes with the flush.
			push_word(~command);
			expected_reads++;
			expected_flushed++;
		end
		wait_idle();
		u_checker.check_value({what, " queue clears"}, u_checker.clear_count, clears + 1);
		u_checker.check_value({what, " error flag"}, o_errors[0], 1);
		u_checker.check_value({what, " interrupt"}, o_interrupt, 1);
		next_cycle();
		i_clear_errors = 1'b1;
		next_cycle();
		i_clear_errors = 1'b0;
		@(negedge clk_rst);
		u_checker.check_value({what, " errors after clear"}, o_errors, 0);
	endtask

	initial begin
		int          count;
		logic [31:0] r;
		logic [3:0]  op;
		seed = 32'h7478_10c9;
		reset_command = 1'b1;
		i_cmd_empty = 1'b1;
		i_cmd_ready = 1'b0;
		i_cmd_data = '0;
		i_transceiver_enable = 1'b0;
		i_stop_transmission = 1'b0;
		i_crc_enable = 1'b0;
		i_clear_errors = 1'b0;
		repeat (8) @(posedge clk_rst);
		#2 reset_command = 1'b0;
		@(negedge clk_rst);
		u_checker.check_value("control outputs after reset", {o_cmd_read, o_tx, o_tx_active,
			o_busy, o_clear_queue, o_errors, o_interrupt, o_start, o_finished}, 0);

		// no command may be read before start-up qualification.
		next_cycle();
		i_transceiver_enable = 1'b1;
		load_crm(1'b1);
		count = 0;
		while (!o_cmd_read) begin
			count++;
			@(negedge clk_rst);
		end
		if (count < (`DSI3_STARTUP_TICKS - 1) * `DSI3_TICK_CYCLES) begin
			u_checker.flag_error($sformatf("command read %0d cycles after enable", count));
		end
		wait_idle();

		for (int i = 0; i < COMMANDS; i++) begin
			r = $random(seed);
			op = r[15:12];
			if (op == 4'd1 || op == 4'd2) begin
				op = op + 4'd4;
			end
			case ($unsigned(r[31:16]) % 10)
				4, 5: run_wait(1 + $unsigned(r[27:20]) % 20);
				6: run_error({4'd1, r[11:1], 1'b0}, "wrong channel");
				7: run_error({op, r[11:1], 1'b1}, "unknown opcode");
				8: run_error({4'd1, r[11:1], 1'b1}, "empty operand");
				default: begin
					load_crm(1'b1);
					wait_idle();
				end
			endcase
		end

		// stop in the middle of a frame.
		load_crm(1'b1);
		@(negedge clk_rst);
		while (!o_tx_active) begin
			@(negedge clk_rst);
		end
		repeat (20) @(negedge clk_rst);
		u_checker.expect_abort();
		next_cycle();
		i_stop_transmission = 1'b1;
		count = 0;
		@(negedge clk_rst);
		while (o_tx_active) begin
			count++;
			@(negedge clk_rst);
		end
		if (count > 2) begin
			u_checker.flag_error($sformatf("tx active %0d cycles after stop", count));
		end
		next_cycle();
		i_stop_transmission = 1'b0;
		wait_idle();

		// enable lost while a wait is running.
		@(negedge clk_rst);
		push_word({4'd2, 11'h000, 1'b1});
		push_word(16'd20);
		expected_reads += 2;
		while (!o_busy || cmd_q.size() != 0) begin
			@(negedge clk_rst);
		end
		repeat (30) @(negedge clk_rst);
		next_cycle();
		i_transceiver_enable = 1'b0;
		repeat (2) @(negedge clk_rst);
		u_checker.check_value("enable lost flag", o_errors[1], 1);
		u_checker.check_value("busy after enable lost", o_busy, 0);

		u_checker.check_value("queue words read", popped_words, expected_reads);
		u_checker.check_value("queue words flushed", cleared_words, expected_flushed);
		u_checker.check_value("CRM frames never sent", u_checker.pending_frames(), 0);
		$display("errors: %0d, frames checked: %0d, queue clears: %0d",
			u_checker.error_count, u_checker.frame_count, u_checker.clear_count);
		if (u_checker.error_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
